// ==== hw/femtoPkg.sv ====
package femtoPkg;

   localparam int XLEN     = 32;  // Data word width
   localparam int NUM_REGS = 32;  // Integer register count

   // Major opcodes, value is instr[6:2]
   typedef enum logic [4:0] {
      OPC_LOAD   = 5'b00000,  // rd <- mem[rs1+Iimm]
      OPC_OPIMM  = 5'b00100,  // rd <- rs1 OP Iimm
      OPC_AUIPC  = 5'b00101,  // rd <- PC + Uimm
      OPC_STORE  = 5'b01000,  // mem[rs1+Simm] <- rs2
      OPC_OP     = 5'b01100,  // rd <- rs1 OP rs2, also MUL/DIV
      OPC_LUI    = 5'b01101,  // rd <- Uimm
      OPC_BRANCH = 5'b11000,  // if (rs1 OP rs2) PC <- PC+Bimm
      OPC_JALR   = 5'b11001,  // rd <- PC+4, PC <- rs1+Iimm
      OPC_JAL    = 5'b11011,  // rd <- PC+4, PC <- PC+Jimm
      OPC_OTHER  = 5'b11111   // Not part of RV32IM
   } opcodeE;

   // Controller states, one bit each
   typedef enum logic [3:0] {
      FETCH_INSTR     = 4'b0001,
      WAIT_INSTR      = 4'b0010,
      EXECUTE         = 4'b0100,
      WAIT_ALU_OR_MEM = 4'b1000
   } coreStateE;

   typedef struct packed {
      opcodeE          opcode;
      logic [4:0]      rdId;
      logic [4:0]      rs1Id;
      logic [4:0]      rs2Id;
      logic [2:0]      funct3;
      logic            altOp;     // instr[30], SUB and SRA
      logic            isMulDiv;  // M extension op
      logic [XLEN-1:0] imm;       // Immediate in the opcode's own format
      logic            useImm;    // Second ALU source is imm
   } decodedT;

   typedef struct packed {
      logic [XLEN-1:0] aluOut;     // Result of the selected operation
      logic [XLEN-1:0] aluPlus;    // Plain sum, also the JALR target
      logic            predicate;  // Branch taken
   } aluResultT;

endpackage

// ==== hw/instrDecoder.sv ====
`timescale 1ns/1ns

module instrDecoder (
   input  logic [31:0]       instr,
   output femtoPkg::decodedT dec
);
   import femtoPkg::*;

   logic [XLEN-1:0] iImm;
   logic [XLEN-1:0] sImm;
   logic [XLEN-1:0] bImm;
   logic [XLEN-1:0] uImm;
   logic [XLEN-1:0] jImm;
   opcodeE          opcode;

   // The five immediate formats, all sign extended from bit 31
   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign uImm = {instr[31:12], 12'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   // Only 32-bit encodings of known majors are accepted
   always_comb begin
      case (opcodeE'(instr[6:2]))
         OPC_LOAD, OPC_OPIMM, OPC_AUIPC, OPC_STORE, OPC_OP,
         OPC_LUI, OPC_BRANCH, OPC_JALR, OPC_JAL:
            opcode = (instr[1:0] == 2'b11) ? opcodeE'(instr[6:2]) : OPC_OTHER;
         default:
            opcode = OPC_OTHER;
      endcase
   end

   always_comb begin
      dec.opcode   = opcode;
      dec.rdId     = instr[11:7];
      dec.rs1Id    = instr[19:15];
      dec.rs2Id    = instr[24:20];
      dec.funct3   = instr[14:12];
      dec.altOp    = instr[30];
      dec.isMulDiv = (opcode == OPC_OP) && instr[25];  // funct7 = 0000001
      // Register forms and branches compare rs1 with rs2
      dec.useImm   = !(opcode inside {OPC_OP, OPC_BRANCH});
      case (opcode)
         OPC_LOAD, OPC_OPIMM, OPC_JALR: dec.imm = iImm;
         OPC_STORE:                     dec.imm = sImm;
         OPC_BRANCH:                    dec.imm = bImm;
         OPC_LUI, OPC_AUIPC:            dec.imm = uImm;
         OPC_JAL:                       dec.imm = jImm;
         default:                       dec.imm = '0;
      endcase
   end

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ns

module regFile (
   input  logic                      CLK,
   input  logic                      readEn,
   input  logic [4:0]                rs1Id,
   input  logic [4:0]                rs2Id,
   output logic [femtoPkg::XLEN-1:0] rs1,
   output logic [femtoPkg::XLEN-1:0] rs2,
   input  logic                      writeEn,
   input  logic [4:0]                rdId,
   input  logic [femtoPkg::XLEN-1:0] writeData
);
   import femtoPkg::*;

   logic [XLEN-1:0] regs [NUM_REGS];  // Entry 0 is never written

   always_ff @(posedge CLK) begin
      if (writeEn && rdId != 5'd0) begin
         regs[rdId] <= writeData;
      end
      // Read ports only move while the instruction word is on the bus
      if (readEn) begin
         rs1 <= (rs1Id == 5'd0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == 5'd0) ? '0 : regs[rs2Id];
      end
   end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ns

module alu (
   input  femtoPkg::decodedT         dec,
   input  logic [femtoPkg::XLEN-1:0] in1,
   input  logic [femtoPkg::XLEN-1:0] in2,
   output logic [femtoPkg::XLEN-1:0] aluOut,
   output logic [femtoPkg::XLEN-1:0] aluPlus,
   output logic                      predicate
);
   import femtoPkg::*;

   logic [XLEN:0]            aluMinus;   // Carry out doubles as unsigned borrow
   logic                     lt;
   logic                     ltu;
   logic                     eq;
   logic [XLEN-1:0]          in1Rev;     // in1 with its bit order reversed
   logic [XLEN-1:0]          shiftIn;
   logic [XLEN:0]            shiftFull;  // Extra MSB carries the SRA sign
   logic [XLEN-1:0]          shifted;
   logic [XLEN-1:0]          leftShift;
   logic [XLEN-1:0]          baseOut;
   logic                     sign1;
   logic                     sign2;
   logic signed [XLEN:0]     mulIn1;
   logic signed [XLEN:0]     mulIn2;
   logic signed [2*XLEN+1:0] product;
   logic [XLEN-1:0]          mulOut;

   // Shared adder, used by ADD, ADDI and JALR
   assign aluPlus = in1 + in2;

   // One 33-bit subtract serves SUB and every comparison
   assign aluMinus = {1'b1, ~in2} + {1'b0, in1} + 1'b1;
   assign lt       = (in1[XLEN-1] ^ in2[XLEN-1]) ? in1[XLEN-1] : aluMinus[XLEN];
   assign ltu      = aluMinus[XLEN];
   assign eq       = (aluMinus[XLEN-1:0] == '0);

   // Left shifts reuse the right shifter on bit-reversed data
   assign in1Rev    = {<<{in1}};
   assign shiftIn   = (dec.funct3 == 3'b001) ? in1Rev : in1;
   assign shiftFull = $signed({dec.altOp & in1[XLEN-1], shiftIn}) >>> in2[4:0];
   assign shifted   = shiftFull[XLEN-1:0];
   assign leftShift = {<<{shifted}};

   always_comb begin
      case (dec.funct3)
         // altOp alone would hit ADDI immediates, so the register form is needed too
         3'b000:  baseOut = (dec.altOp && dec.opcode == OPC_OP) ? aluMinus[XLEN-1:0]
                                                                 : aluPlus;
         3'b001:  baseOut = leftShift;
         3'b010:  baseOut = XLEN'(lt);
         3'b011:  baseOut = XLEN'(ltu);
         3'b100:  baseOut = in1 ^ in2;
         3'b101:  baseOut = shifted;           // SRL or SRA
         3'b110:  baseOut = in1 | in2;
         default: baseOut = in1 & in2;
      endcase
   end

   // MULH signs both operands, MULHSU only the first
   assign sign1   = in1[XLEN-1] & (dec.funct3 == 3'b001 || dec.funct3 == 3'b010);
   assign sign2   = in2[XLEN-1] & (dec.funct3 == 3'b001);
   assign mulIn1  = {sign1, in1};
   assign mulIn2  = {sign2, in2};
   assign product = mulIn1 * mulIn2;

   // DIV/REM codes land here too, the core takes the divider result instead
   assign mulOut = (dec.funct3 == 3'b000) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];

   assign aluOut = dec.isMulDiv ? mulOut : baseOut;

   always_comb begin
      case (dec.funct3)
         3'b000:  predicate = eq;    // BEQ
         3'b001:  predicate = !eq;   // BNE
         3'b100:  predicate = lt;    // BLT
         3'b101:  predicate = !lt;   // BGE
         3'b110:  predicate = ltu;   // BLTU
         3'b111:  predicate = !ltu;  // BGEU
         default: predicate = 1'b0;
      endcase
   end

endmodule

// ==== hw/divider.sv ====
`timescale 1ns/1ns

module divider (
   input  logic        CLK,
   input  logic        RST,
   input  logic        start,
   input  logic [2:0]  funct3,
   input  logic [31:0] dividend,
   input  logic [31:0] divisor,
   output logic [31:0] divOut,
   output logic        busy
);

   logic [31:0] remainder;    // Shrinks as the divisor is subtracted
   logic [62:0] divisorSh;    // Divisor walking down from bit 62
   logic [31:0] quotient;
   logic [31:0] quotientMsk;  // One bit per remaining step
   logic [31:0] divResult;
   logic        wantRem;      // REM or REMU
   logic        negResult;
   logic        isSigned;
   logic        stepDo;
   logic [31:0] remainderN;
   logic [31:0] quotientN;

   assign isSigned   = ~funct3[0];  // DIV and REM
   assign stepDo     = (divisorSh <= {31'b0, remainder});
   assign remainderN = stepDo ? remainder - divisorSh[31:0] : remainder;
   assign quotientN  = stepDo ? (quotient | quotientMsk) : quotient;

   assign busy   = |quotientMsk;
   assign divOut = negResult ? -divResult : divResult;

   always_ff @(posedge CLK) begin
      if (RST) begin
         quotientMsk <= '0;
      end else if (start) begin
         quotientMsk <= 32'h8000_0000;
      end else begin
         quotientMsk <= quotientMsk >> 1;  // Reaches zero after 32 steps
      end
   end

   // Work on magnitudes, the sign is put back on the way out
   always_ff @(posedge CLK) begin
      if (start) begin
         remainder <= (isSigned && dividend[31]) ? -dividend : dividend;
         divisorSh <= {((isSigned && divisor[31]) ? -divisor : divisor), 31'b0};
         quotient  <= '0;
         wantRem   <= funct3[1];
         // Remainder follows the dividend, quotient the xor, zero divisor stays -1
         negResult <= isSigned & (funct3[1] ? dividend[31]
                                            : (dividend[31] ^ divisor[31]) & (|divisor));
      end else begin
         remainder <= remainderN;
         divisorSh <= divisorSh >> 1;
         quotient  <= quotientN;
      end
      divResult <= wantRem ? remainderN : quotientN;
   end

endmodule

// ==== hw/loadStoreUnit.sv ====
`timescale 1ns/1ns

module loadStoreUnit #(
   parameter int addrWidth = 24
) (
   input  femtoPkg::decodedT         dec,
   input  logic [femtoPkg::XLEN-1:0] rs1,
   input  logic [femtoPkg::XLEN-1:0] rs2,
   input  logic [femtoPkg::XLEN-1:0] rData,
   output logic [femtoPkg::XLEN-1:0] addr,
   output logic [femtoPkg::XLEN-1:0] wData,
   output logic [3:0]                storeMask,
   output logic [femtoPkg::XLEN-1:0] loadData
);
   import femtoPkg::*;

   logic [addrWidth-1:0] lsAddr;
   logic                 byteAccess;
   logic                 halfAccess;
   logic                 loadSign;
   logic [15:0]          loadHalf;
   logic [7:0]           loadByte;

   // imm is already Simm for stores and Iimm for loads
   assign lsAddr = rs1[addrWidth-1:0] + dec.imm[addrWidth-1:0];
   assign addr   = XLEN'(lsAddr);

   assign byteAccess = (dec.funct3[1:0] == 2'b00);
   assign halfAccess = (dec.funct3[1:0] == 2'b01);

   // Replicate the low byte/half so every lane sees it
   assign wData[7:0]   = rs2[7:0];
   assign wData[15:8]  = lsAddr[0] ? rs2[7:0] : rs2[15:8];
   assign wData[23:16] = lsAddr[1] ? rs2[7:0] : rs2[23:16];
   assign wData[31:24] = lsAddr[0] ? rs2[7:0] : lsAddr[1] ? rs2[15:8] : rs2[31:24];

   always_comb begin
      if (byteAccess)
         storeMask = 4'b0001 << lsAddr[1:0];
      else if (halfAccess)
         storeMask = lsAddr[1] ? 4'b1100 : 4'b0011;
      else
         storeMask = 4'b1111;
   end

   // Pick the addressed half, then the byte inside it
   assign loadHalf = lsAddr[1] ? rData[31:16] : rData[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !dec.funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  rData;

endmodule

// ==== hw/femtoCore.sv ====
`timescale 1ns/1ns

module femtoCore #(
   parameter logic [31:0] resetAddr = 32'h0,
   parameter int          addrWidth = 24
) (
   input  logic        CLK,
   input  logic        RST,
   output logic [31:0] addr,
   output logic [31:0] wData,
   output logic [3:0]  wMask,
   input  logic [31:0] rData,
   output logic        rStrb,
   input  logic        rBusy,
   input  logic        wBusy
);
   import femtoPkg::*;

   localparam logic [31:0] NOP = 32'h0000_0013;  // addi x0, x0, 0

   coreStateE            state;
   logic [addrWidth-1:0] pc;
   logic [31:0]          instr;        // Latched instruction word
   decodedT              dec;
   aluResultT            aluRes;
   logic [XLEN-1:0]      rs1;
   logic [XLEN-1:0]      rs2;
   logic [XLEN-1:0]      aluIn2;
   logic [XLEN-1:0]      divOut;
   logic [XLEN-1:0]      lsAddr;
   logic [XLEN-1:0]      loadData;
   logic [XLEN-1:0]      writeData;
   logic [XLEN-1:0]      pcPlusImm;    // Branch, JAL and AUIPC
   logic [3:0]           storeMask;
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcNew;
   logic                 isLoad;
   logic                 isStore;
   logic                 isBranch;
   logic                 isDiv;
   logic                 divBusy;
   logic                 memPhase;
   logic                 writeEn;

   instrDecoder u_instrDecoder (
      .instr (instr),
      .dec   (dec)
   );

   // Register ids come straight off the bus while the word arrives
   regFile u_regFile (
      .CLK       (CLK),
      .readEn    (state == WAIT_INSTR && !rBusy),
      .rs1Id     (rData[19:15]),
      .rs2Id     (rData[24:20]),
      .rs1       (rs1),
      .rs2       (rs2),
      .writeEn   (writeEn),
      .rdId      (dec.rdId),
      .writeData (writeData)
   );

   assign aluIn2 = dec.useImm ? dec.imm : rs2;

   alu u_alu (
      .dec       (dec),
      .in1       (rs1),
      .in2       (aluIn2),
      .aluOut    (aluRes.aluOut),
      .aluPlus   (aluRes.aluPlus),
      .predicate (aluRes.predicate)
   );

   divider u_divider (
      .CLK      (CLK),
      .RST      (RST),
      .start    (state == EXECUTE && isDiv),
      .funct3   (dec.funct3),
      .dividend (rs1),
      .divisor  (rs2),
      .divOut   (divOut),
      .busy     (divBusy)
   );

   loadStoreUnit #(
      .addrWidth (addrWidth)
   ) u_loadStoreUnit (
      .dec       (dec),
      .rs1       (rs1),
      .rs2       (rs2),
      .rData     (rData),
      .addr      (lsAddr),
      .wData     (wData),
      .storeMask (storeMask),
      .loadData  (loadData)
   );

   assign isLoad   = (dec.opcode == OPC_LOAD);
   assign isStore  = (dec.opcode == OPC_STORE);
   assign isBranch = (dec.opcode == OPC_BRANCH);
   assign isDiv    = dec.isMulDiv & dec.funct3[2];  // DIV, DIVU, REM, REMU

   assign pcPlus4   = pc + addrWidth'(4);
   assign pcPlusImm = XLEN'(pc) + dec.imm;  // Full width for AUIPC

   always_comb begin
      if (dec.opcode == OPC_JALR)
         pcNew = {aluRes.aluPlus[addrWidth-1:1], 1'b0};
      else if (dec.opcode == OPC_JAL || (isBranch && aluRes.predicate))
         pcNew = pcPlusImm[addrWidth-1:0];
      else
         pcNew = pcPlus4;
   end

   always_comb begin
      case (dec.opcode)
         OPC_LUI:           writeData = dec.imm;
         OPC_AUIPC:         writeData = pcPlusImm;
         OPC_OP, OPC_OPIMM: writeData = isDiv ? divOut : aluRes.aluOut;
         OPC_JAL, OPC_JALR: writeData = XLEN'(pcPlus4);  // Link
         OPC_LOAD:          writeData = loadData;
         default:           writeData = '0;
      endcase
   end

   // Rewritten every wait cycle, the last one carries the final value
   assign writeEn = (state == EXECUTE || state == WAIT_ALU_OR_MEM) && !isBranch && !isStore;

   // Data address only for the memory op in flight, PC otherwise
   assign memPhase = (state == EXECUTE || state == WAIT_ALU_OR_MEM) && (isLoad || isStore);
   assign addr     = memPhase ? lsAddr : XLEN'({pc[addrWidth-1:2], 2'b00});
   assign rStrb    = (state == FETCH_INSTR) || (state == EXECUTE && isLoad);
   assign wMask    = (state == EXECUTE && isStore) ? storeMask : 4'b0000;

   always_ff @(posedge CLK) begin
      if (RST) begin
         state <= WAIT_ALU_OR_MEM;  // Let both busy levels drop first
         pc    <= resetAddr[addrWidth-1:0];
         instr <= NOP;
      end else begin
         case (state)
            FETCH_INSTR: begin
               state <= WAIT_INSTR;
            end
            WAIT_INSTR: begin
               if (!rBusy) begin
                  instr <= rData;
                  state <= EXECUTE;
               end
            end
            EXECUTE: begin
               pc    <= pcNew;
               state <= (isLoad || isStore || isDiv) ? WAIT_ALU_OR_MEM : FETCH_INSTR;
            end
            WAIT_ALU_OR_MEM: begin
               if (!divBusy && !rBusy && !wBusy) state <= FETCH_INSTR;
            end
            default: state <= WAIT_ALU_OR_MEM;  // Recover from an illegal code
         endcase
      end
   end

endmodule

// ==== tests/femtoCore_properties.sv ====
`timescale 1ns/1ns

module femtoCoreProperties #(
   parameter logic [31:0] resetAddr = 32'h0
) (
   input logic                CLK,
   input logic                RST,
   input logic [31:0]         addr,
   input logic [3:0]          wMask,
   input logic                rStrb,
   input logic                rBusy,
   input logic                wBusy,
   input femtoPkg::coreStateE state
);
   import femtoPkg::*;

   int   failCount = 0;
   logic seenFetch;  // First strobe since reset went by

   always_ff @(posedge CLK) begin
      if (RST) seenFetch <= 1'b0;
      else if (rStrb) seenFetch <= 1'b1;
   end

   resetQuiet: assert property (@(posedge CLK) RST |-> !rStrb && wMask == 4'b0)
      else begin $error("Bus active during reset"); failCount++; end
   afterReset: assert property (@(posedge CLK) $fell(RST) |-> !rStrb && wMask == 4'b0)
      else begin $error("Bus active in the cycle after reset"); failCount++; end
   firstFetch: assert property (@(posedge CLK) disable iff (RST)
                                rStrb && !seenFetch |-> addr == resetAddr)
      else begin $error("First fetch is not at the reset address"); failCount++; end
   // Memory busy means the core keeps still
   busyQuiet: assert property (@(posedge CLK) disable iff (RST)
                               (rBusy || wBusy) |-> !rStrb && wMask == 4'b0)
      else begin $error("Strobe or write while memory busy"); failCount++; end
   addrHold: assert property (@(posedge CLK) disable iff (RST)
                              state == WAIT_ALU_OR_MEM && $past(state) == WAIT_ALU_OR_MEM
                              |-> $stable(addr))
      else begin $error("Address moved during a wait"); failCount++; end

endmodule

bind femtoCore femtoCoreProperties #(.resetAddr(resetAddr)) u_props (
   .CLK (CLK), .RST (RST), .addr (addr), .wMask (wMask), .rStrb (rStrb),
   .rBusy (rBusy), .wBusy (wBusy), .state (state)
);

// ==== tests/femtoCoreTb.sv ====
`timescale 1ns/1ns

module femtoCoreTb;
   localparam int          MEM_WORDS = 1024;          // 4 KB
   localparam int          RES_BASE  = 512;           // Result slots at 0x800
   localparam int          POI_BASE  = 768;           // Poison slots at 0xC00
   localparam int          DONE_WORD = 1023;          // 0xFFC ends the program
   localparam int          TIMEOUT   = 60000;
   localparam logic [6:0]  OPC7_LUI  = 7'b0110111;
   localparam logic [6:0]  OPC7_AUI  = 7'b0010111;
   localparam logic [6:0]  OPC7_IMM  = 7'b0010011;
   localparam logic [6:0]  OPC7_LOAD = 7'b0000011;
   localparam logic [6:0]  OPC7_JALR = 7'b1100111;

   logic        CLK   = 1'b0;
   logic        RST   = 1'b1;
   logic        rBusy = 1'b0;
   logic        wBusy = 1'b0;
   logic [31:0] rData = '0;
   logic [31:0] addr;
   logic [31:0] wData;
   logic [3:0]  wMask;
   logic        rStrb;
   logic        done  = 1'b0;
   logic [31:0] mem [MEM_WORDS];
   logic [31:0] prog [MEM_WORDS];   // Image copied into mem during reset
   logic [31:0] expv [256];         // Expected slot values
   int          nSlot   = 0;
   int          pcIdx   = 0;
   int          nPoison = 0;
   int          errors  = 0;
   int          groupEnd [4];
   logic        timedOut;

   femtoCore u_femtoCore (
      .CLK (CLK), .RST (RST), .addr (addr), .wData (wData), .wMask (wMask),
      .rData (rData), .rStrb (rStrb), .rBusy (rBusy), .wBusy (wBusy)
   );

   always #4 CLK = ~CLK;

   // Every bit of the word index shows up in the pattern
   function automatic logic [31:0] fillWord(input int i);
      return {6'h2a, i[9:0], ~i[9:0], 6'h15};
   endfunction

   function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {f7, rs2, rs1, f3, 5'd3, 7'b0110011};  // rd is always x3
   endfunction
   function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction
   function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
   endfunction
   function automatic logic [31:0] bType(input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [2:0] f3);
      return {1'b0, 6'd0, rs2, rs1, f3, 4'd4, 1'b0, 7'b1100011};  // Always +8
   endfunction
   function automatic logic [31:0] uType(input logic [19:0] u, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {u, rd, opc};
   endfunction
   function automatic logic [31:0] jType(input logic [20:0] i, input logic [4:0] rd);
      return {i[20], i[10:1], i[11], i[19:12], rd, 7'b1101111};
   endfunction

   task automatic emit(input logic [31:0] w);
      prog[pcIdx] = w;
      pcIdx++;
   endtask
   task automatic li(input logic [4:0] rd, input logic [31:0] v);
      logic [31:0] hi;
      hi = (v + 32'h800) >> 12;  // Round up when ADDI subtracts
      emit(uType(hi[19:0], rd, OPC7_LUI));
      emit(iType(v[11:0], rd, 3'b000, rd, OPC7_IMM));
   endtask
   task automatic storeReg(input logic [4:0] rs, input logic [31:0] value);
      emit(sType(12'(nSlot * 4), rs, 5'd10, 3'b010));
      expv[nSlot] = value;
      nSlot++;
   endtask
   task automatic opR(input logic [6:0] f7, input logic [4:0] rs2, input logic [2:0] f3,
                      input logic [31:0] value);
      emit(rType(f7, rs2, 5'd1, f3));
      storeReg(5'd3, value);
   endtask
   task automatic poison();
      emit(sType(12'(nPoison * 4), 5'd1, 5'd11, 3'b010));  // Only runs on a wrong path
      nPoison++;
   endtask

   task automatic buildProgram();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] iv;
      longint      sa;
      longint      sb;
      longint      p;
      logic [63:0] up;
      int          ia;
      int          ib;
      int          s0;
      for (int i = 0; i < MEM_WORDS; i++) prog[i] = fillWord(i);
      a  = $urandom | 32'h8000_0000;  // Negative, so SRA shows the sign
      b  = $urandom;
      iv = $urandom;
      li(5'd10, 32'h800);
      li(5'd11, 32'hC00);
      li(5'd1, a);
      li(5'd2, b);
      opR(7'h00, 5'd2, 3'd0, a + b);
      opR(7'h20, 5'd2, 3'd0, a - b);
      opR(7'h00, 5'd2, 3'd1, a << b[4:0]);
      opR(7'h00, 5'd2, 3'd5, a >> b[4:0]);
      opR(7'h20, 5'd2, 3'd5, $signed(a) >>> b[4:0]);
      opR(7'h00, 5'd2, 3'd2, {31'b0, $signed(a) < $signed(b)});
      opR(7'h00, 5'd2, 3'd3, {31'b0, a < b});
      opR(7'h00, 5'd2, 3'd4, a ^ b);
      opR(7'h00, 5'd2, 3'd6, a | b);
      opR(7'h00, 5'd2, 3'd7, a & b);
      emit(iType(iv[11:0], 5'd1, 3'd0, 5'd3, OPC7_IMM));
      storeReg(5'd3, a + {{20{iv[11]}}, iv[11:0]});
      emit(iType(12'h407, 5'd1, 3'd5, 5'd3, OPC7_IMM));  // SRAI by 7
      storeReg(5'd3, $signed(a) >>> 7);
      emit(uType(iv[31:12], 5'd3, OPC7_LUI));
      storeReg(5'd3, {iv[31:12], 12'b0});
      s0 = pcIdx;
      emit(uType(iv[31:12], 5'd3, OPC7_AUI));
      storeReg(5'd3, 32'(s0 * 4) + {iv[31:12], 12'b0});
      groupEnd[0] = nSlot;

      // Both operands negative, so the divisor is too
      a  = $urandom | 32'h8000_0000;
      b  = $urandom | 32'h8000_0000;
      sa = $signed(a);
      sb = $signed(b);
      ia = $signed(a);
      ib = $signed(b);
      li(5'd1, a);
      li(5'd2, b);
      opR(7'h01, 5'd2, 3'd0, a * b);
      p = sa * sb;
      opR(7'h01, 5'd2, 3'd1, p[63:32]);
      p = sa * longint'({32'h0, b});
      opR(7'h01, 5'd2, 3'd2, p[63:32]);
      up = {32'h0, a} * {32'h0, b};
      opR(7'h01, 5'd2, 3'd3, up[63:32]);
      opR(7'h01, 5'd2, 3'd4, ia / ib);
      opR(7'h01, 5'd2, 3'd5, a / b);
      opR(7'h01, 5'd2, 3'd6, ia % ib);
      opR(7'h01, 5'd2, 3'd7, a % b);
      opR(7'h01, 5'd0, 3'd4, 32'hFFFF_FFFF);  // x0 divisor
      opR(7'h01, 5'd0, 3'd5, 32'hFFFF_FFFF);
      opR(7'h01, 5'd0, 3'd6, a);
      opR(7'h01, 5'd0, 3'd7, a);
      groupEnd[1] = nSlot;

      a  = $urandom | 32'h0000_8080;  // Byte and half both read back negative
      s0 = nSlot;
      li(5'd1, a);
      emit(sType(12'(s0 * 4 + 1), 5'd1, 5'd10, 3'b000));  // SB to lane 1
      expv[s0] = fillWord(RES_BASE + s0);
      expv[s0][15:8] = a[7:0];
      emit(sType(12'(s0 * 4 + 6), 5'd1, 5'd10, 3'b001));  // SH to lanes 2,3
      expv[s0 + 1] = fillWord(RES_BASE + s0 + 1);
      expv[s0 + 1][31:16] = a[15:0];
      nSlot += 2;
      emit(iType(12'(s0 * 4 + 1), 5'd10, 3'b000, 5'd3, OPC7_LOAD));
      storeReg(5'd3, {{24{a[7]}}, a[7:0]});
      emit(iType(12'(s0 * 4 + 1), 5'd10, 3'b100, 5'd3, OPC7_LOAD));
      storeReg(5'd3, {24'b0, a[7:0]});
      emit(iType(12'(s0 * 4 + 6), 5'd10, 3'b001, 5'd3, OPC7_LOAD));
      storeReg(5'd3, {{16{a[15]}}, a[15:0]});
      emit(iType(12'(s0 * 4 + 6), 5'd10, 3'b101, 5'd3, OPC7_LOAD));
      storeReg(5'd3, {16'b0, a[15:0]});
      groupEnd[2] = nSlot;

      a = $urandom | 32'h8000_0000;  // x1 negative, x2 positive
      b = $urandom & 32'h7FFF_FFFF;
      li(5'd1, a);
      li(5'd2, b);
      emit(bType(5'd1, 5'd1, 3'd0));  // BEQ taken
      poison();
      emit(bType(5'd1, 5'd1, 3'd1));  // BNE falls through
      storeReg(5'd1, a);
      emit(bType(5'd1, 5'd2, 3'd4));  // BLT taken
      poison();
      emit(bType(5'd1, 5'd2, 3'd6));  // BLTU falls through
      storeReg(5'd2, b);
      emit(bType(5'd2, 5'd1, 3'd5));  // BGE taken
      poison();
      emit(bType(5'd1, 5'd2, 3'd7));  // BGEU taken
      poison();
      s0 = pcIdx;
      emit(jType(21'd8, 5'd3));
      poison();
      storeReg(5'd3, 32'(s0 * 4 + 4));
      s0 = pcIdx;
      emit(uType(20'd0, 5'd5, OPC7_AUI));
      emit(iType(12'd12, 5'd5, 3'd0, 5'd3, OPC7_JALR));  // Lands past the poison
      poison();
      storeReg(5'd3, 32'(s0 * 4 + 8));
      groupEnd[3] = nSlot;

      emit(uType(20'd1, 5'd6, OPC7_LUI));
      emit(sType(12'hFFC, 5'd0, 5'd6, 3'b010));  // Done store at 0xFFC
      emit(jType(21'd0, 5'd0));                  // Park
   endtask

   // Memory with random busy levels after each access
   always @(posedge CLK) begin
      if (RST) begin
         for (int i = 0; i < MEM_WORDS; i++) mem[i] <= prog[i];
         rBusy <= 1'b0;
         wBusy <= 1'b0;
         done  <= 1'b0;
      end else begin
         if (rStrb) begin
            rData <= mem[addr[11:2]];
            rBusy <= ($urandom % 3) == 0;
         end else if (rBusy) begin
            rBusy <= ($urandom % 2) == 0;
         end
         if (wMask != 4'b0) begin
            for (int l = 0; l < 4; l++)
               if (wMask[l]) mem[addr[11:2]][8*l +: 8] <= wData[8*l +: 8];
            wBusy <= ($urandom % 3) == 0;
            if (addr[11:2] == DONE_WORD) done <= 1'b1;
         end else if (wBusy) begin
            wBusy <= ($urandom % 2) == 0;
         end
      end
   end

   task automatic checkGroup(input string name, input int first, input int last);
      int errs;
      errs = 0;
      for (int i = first; i < last; i++) begin
         assert (mem[RES_BASE + i] == expv[i]) else begin
            $display("ERROR %0t: %s slot %0d is %h, expected %h",
                     $time, name, i, mem[RES_BASE + i], expv[i]);
            errs++;
         end
      end
      errors += errs;
      $display("%s: %0d slots, %0d errors", name, last - first, errs);
   endtask

   initial begin
      void'($urandom(32'h427e8cd5));
      buildProgram();
      repeat (10) @(posedge CLK);
      RST <= 1'b0;
      timedOut = 1'b1;
      for (int c = 0; c < TIMEOUT && timedOut; c++) begin
         @(posedge CLK);
         if (done) timedOut = 1'b0;
      end
      if (timedOut) begin
         $display("Timed out waiting for the end-of-program store");
      end else begin
         repeat (4) @(posedge CLK);
         checkGroup("base ops", 0, groupEnd[0]);
         checkGroup("mul/div", groupEnd[0], groupEnd[1]);
         checkGroup("sub-word", groupEnd[1], groupEnd[2]);
         checkGroup("control flow", groupEnd[2], groupEnd[3]);
         for (int i = 0; i < nPoison; i++) begin
            assert (mem[POI_BASE + i] == fillWord(POI_BASE + i)) else begin
               $display("ERROR %0t: poison slot %0d was written", $time, i);
               errors++;
            end
         end
         $display("reset and back-pressure: %0d assertion failures",
                  u_femtoCore.u_props.failCount);
      end
      $display("Closing: %0d slots, %0d poison slots, %0d errors", nSlot, nPoison, errors);
      if (!timedOut && errors == 0 && u_femtoCore.u_props.failCount == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== femtoCore.f ====
hw/femtoPkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/alu.sv
hw/divider.sv
hw/loadStoreUnit.sv
hw/femtoCore.sv
tests/femtoCore_properties.sv
tests/femtoCoreTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module femtoCoreTb \
   -f femtoCore.f -o simv || exit 1
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS" && exit 0 || exit 1
